// ==== compile.f ====
rtl/sgd_data_pkg.sv
rtl/sgd_ctrl_pkg.sv
rtl/plane_fifo.sv
rtl/plane_buffer.sv
rtl/plane_sequencer.sv
rtl/adder_tree.sv
rtl/bank_dot_unit.sv
rtl/sgd_dot_product.sv
test/tb_sgd_dot_product.sv

// ==== Makefile ====
TOP := tb_sgd_dot_product

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module sgd_dot_product

sim:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/tb_sgd_dot_product.sv ====
// sgd_dot_product testbench with x memory model, lcg stimulus, reference model and directed tests
`timescale 1ns/1ps

module tb_sgd_dot_product
    import sgd_data_pkg::*;
    import sgd_ctrl_pkg::*;
();
    localparam int NB        = 4;
    localparam int BL        = 8;
    localparam int TD        = 3;
    localparam int FDB       = 4;
    localparam int XAB       = 6;
    localparam int W         = NB * BL;     // plane word
    localparam int XW        = BL * 32;     // x word
    localparam int TIMEOUT   = 2000;        // cycles per wait
    localparam int GATE_WAIT = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  start_i;
    plane_idx_t            bits_i;
    logic [31:0]           dimension_i;
    sample_cnt_t           samples_i;
    epoch_cnt_t            epochs_i;
    logic [W-1:0]          a_data_i;
    logic                  a_valid_i;
    logic                  x_ready_i;
    logic [XW-1:0]         x_data_i = '0;
    logic                  a_ready_o;
    logic [XAB-1:0]        x_addr_o;
    x_elem_t [NB-1:0]      dot_o;
    logic [NB-1:0]         dot_valid_o;
    logic                  done_o;

    logic [XW-1:0]         xmem [1 << XAB];     // model vector with BL elements per chunk
    logic [XAB-1:0]        x_addr_q = '0;
    logic [W-1:0]          word_q [$];          // plane words still to send
    x_elem_t               exp_q [$];           // expected results in bank order per group
    logic [31:0]           lcg_state;
    int                    checks;
    int                    errors;
    int                    tests_run;
    int                    tests_failed;

    sgd_dot_product #(
        .NUM_BANKS       (NB),
        .BANK_LANES      (BL),
        .TREE_DEPTH      (TD),
        .FIFO_DEPTH_BITS (FDB),
        .X_ADDR_BITS     (XAB)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .bits_i      (bits_i),
        .dimension_i (dimension_i),
        .samples_i   (samples_i),
        .epochs_i    (epochs_i),
        .a_data_i    (a_data_i),
        .a_valid_i   (a_valid_i),
        .x_ready_i   (x_ready_i),
        .x_data_i    (x_data_i),
        .a_ready_o   (a_ready_o),
        .x_addr_o    (x_addr_o),
        .dot_o       (dot_o),
        .dot_valid_o (dot_valid_o),
        .done_o      (done_o)
    );

    always #4 clk = ~clk;   // 8 ns period

    // x memory with one clk of read latency
    always @(negedge clk)
    begin
        x_data_i = xmem[x_addr_q];     // address from the previous cycle
        x_addr_q = x_addr_o;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic x_elem_t rand_x();
        logic [31:0] r;
        r = lcg_next();
        return x_elem_t'((r >> 8) % 32'd2001) - 32'sd1000;   // -1000..1000
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'((r >> 8) % 32'(n));
    endfunction

    function automatic logic [W-1:0] rand_word();
        logic [W-1:0] w;
        logic [31:0]  r;
        for (int i = 0; i < W; i++)
        begin
            r    = lcg_next();
            w[i] = r[27];   // upper bit since low lcg bits cycle short
        end
        return w;
    endfunction

    task automatic report_timeout(input string why);
        errors++;
        $display("timeout: %s", why);
    endtask

    task automatic check_dot(input x_elem_t got, input x_elem_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0d ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs0);
        tests_run++;
        if (errors > errs0)
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs0);
        end
        else
            $display("test %s: ok", name);
    endtask

    task automatic fill_x();
        for (int a = 0; a < (1 << XAB); a++)
            for (int j = 0; j < BL; j++)
                xmem[a][j*32 +: 32] = rand_x();
    endtask

    // random planes of one sample group and the expected dot per bank
    task automatic build_group(input int bits, input int chunks);
        longint       acc [NB];
        longint       s;
        logic [W-1:0] w;
        x_elem_t      xe;
        for (int b = 0; b < NB; b++)
            acc[b] = 0;
        for (int c = 0; c < chunks; c++)
            for (int k = 0; k < bits; k++)
            begin
                w = rand_word();
                word_q.push_back(w);
                for (int b = 0; b < NB; b++)
                begin
                    s = 0;
                    for (int j = 0; j < BL; j++)
                        if (w[b*BL + j])
                        begin
                            xe = xmem[c][j*32 +: 32];
                            s += longint'(xe);
                        end
                    acc[b] += (s * 16) >>> (k + 1);     // plane k weighs 2^-(k+1)
                end
            end
        for (int b = 0; b < NB; b++)
            exp_q.push_back(x_elem_t'(acc[b] >>> 4));   // drop 4 fraction bits
    endtask

    task automatic configure(input int bits, input int chunks, input int groups, input int epochs);
        bits_i      = plane_idx_t'(bits);
        dimension_i = 32'(chunks * BL);
        samples_i   = sample_cnt_t'(groups * NB);
        epochs_i    = epoch_cnt_t'(epochs);
        @(negedge clk);     // chunk count registered inside
    endtask

    task automatic pulse_start();
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic push_words(input bit gaps);
        int guard;
        while (word_q.size() > 0)
        begin
            if (gaps)
            begin
                a_valid_i = 1'b0;
                repeat (rand_below(4)) @(negedge clk);
            end
            a_data_i  = word_q.pop_front();
            a_valid_i = 1'b1;
            guard     = 0;
            while (!a_ready_o && guard < TIMEOUT)
            begin
                @(negedge clk);
                guard++;
            end
            if (!a_ready_o)
            begin
                report_timeout("a_ready_o never came back, input word stuck");
                word_q.delete();    // give up on the rest
            end
            else
                @(negedge clk);     // transfer on the edge just passed
        end
        a_valid_i = 1'b0;
    endtask

    task automatic wait_result();
        int guard;
        guard = 0;
        while (dot_valid_o == '0 && guard < TIMEOUT)
        begin
            @(negedge clk);
            guard++;
        end
        if (dot_valid_o == '0)
            report_timeout("no result pulse on dot_valid_o");
    endtask

    task automatic collect_results(input int groups);
        for (int g = 0; g < groups; g++)
        begin
            wait_result();
            check_flag(&dot_valid_o, 1'b1, "all banks valid in one cycle");
            for (int b = 0; b < NB; b++)
                check_dot(dot_o[b], exp_q.pop_front(), $sformatf("group %0d bank %0d", g, b));
            @(negedge clk);
            check_flag(|dot_valid_o, 1'b0, "dot_valid_o one cycle wide");
        end
    endtask

    task automatic wait_done();
        int guard;
        guard = 0;
        while (!done_o && guard < TIMEOUT)
        begin
            @(negedge clk);
            guard++;
        end
        check_flag(done_o, 1'b1, "done_o after last result");
    endtask

    task automatic wait_ready_low();
        int guard;
        guard = 0;
        while (a_ready_o && guard < TIMEOUT)
        begin
            @(negedge clk);
            guard++;
        end
        check_flag(a_ready_o, 1'b0, "a_ready_o falls on a full fifo");
    endtask

    // single epoch job with supply and collection run in parallel
    task automatic run_job(input string name, input int bits, input int chunks,
                           input int groups, input bit gaps, input bit hold_start);
        int errs0;
        errs0 = errors;
        configure(bits, chunks, groups, 1);
        for (int g = 0; g < groups; g++)
            build_group(bits, chunks);
        fork
            push_words(gaps);
            begin
                if (hold_start)
                    wait_ready_low();   // fifo fills up first
                pulse_start();
                collect_results(groups);
            end
        join
        wait_done();
        end_test(name, errs0);
    endtask

    task automatic test_reset();
        int             errs0;
        logic [XAB-1:0] addr0;
        errs0 = errors;
        check_flag(|dot_valid_o, 1'b0, "dot_valid_o after reset");
        check_flag(done_o, 1'b0, "done_o after reset");
        check_flag(a_ready_o, 1'b1, "a_ready_o after reset");
        addr0 = x_addr_o;
        repeat (4) @(negedge clk);
        check_flag(x_addr_o == addr0, 1'b1, "x_addr_o stable while idle");
        end_test("reset state", errs0);
    endtask

    task automatic test_epoch_gate();
        int errs0;
        int pulses;
        errs0     = errors;
        pulses    = 0;
        x_ready_i = 1'b0;
        configure(3, 1, 1, 2);
        build_group(3, 1);
        fork
            push_words(1'b0);
            begin
                pulse_start();
                collect_results(1);
            end
        join
        fill_x();               // host writes the updated x
        build_group(3, 1);
        push_words(1'b0);       // second epoch data fits in one fifo
        for (int i = 0; i < GATE_WAIT; i++)
        begin
            @(negedge clk);
            if (|dot_valid_o)
                pulses++;
        end
        check_flag(pulses == 0, 1'b1, "no result while x_ready_i low");
        check_flag(done_o, 1'b0, "done_o while gated");
        x_ready_i = 1'b1;
        collect_results(1);
        wait_done();
        x_ready_i = 1'b0;
        end_test("epoch gate", errs0);
    endtask

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        start_i      = 1'b0;
        bits_i       = '0;
        dimension_i  = '0;
        samples_i    = '0;
        epochs_i     = '0;
        a_data_i     = '0;
        a_valid_i    = 1'b0;
        x_ready_i    = 1'b0;
        lcg_state    = 32'd94530;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        fill_x();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        test_reset();

        run_job("single plane", 1, 1, 1, 1'b0, 1'b0);   // floor(S/2) per bank

        fill_x();
        run_job("random planes and chunks", 5, 3, 1, 1'b0, 1'b0);

        run_job("results in order", 4, 2, 3, 1'b0, 1'b0);   // three groups back to back

        run_job("input back-pressure", 8, 4, 1, 1'b1, 1'b1);   // 32 words exceed one fifo

        test_epoch_gate();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== rtl/sgd_dot_product.sv ====
// top level: plane buffer, sequencer, x register and per-bank dot units
`timescale 1ns/1ps

module sgd_dot_product
    import sgd_data_pkg::*;
    import sgd_ctrl_pkg::*;
#(
    parameter int NUM_BANKS       = 4,
    parameter int BANK_LANES      = 8,
    parameter int TREE_DEPTH      = 3,      // log2 of BANK_LANES
    parameter int FIFO_DEPTH_BITS = 4,
    parameter int X_ADDR_BITS     = 6
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start_i,
    input  plane_idx_t                      bits_i,
    input  logic [31:0]                     dimension_i,
    input  sample_cnt_t                     samples_i,
    input  epoch_cnt_t                      epochs_i,
    input  logic [NUM_BANKS*BANK_LANES-1:0] a_data_i,
    input  logic                            a_valid_i,
    input  logic                            x_ready_i,
    input  logic [BANK_LANES*32-1:0]        x_data_i,
    output logic                            a_ready_o,
    output logic [X_ADDR_BITS-1:0]          x_addr_o,
    output x_elem_t [NUM_BANKS-1:0]         dot_o,
    output logic [NUM_BANKS-1:0]            dot_valid_o,
    output logic                            done_o
);
    chunk_idx_t                      chunks_q;
    x_elem_t [BANK_LANES-1:0]        x_q;           // lines up with plane_valid
    logic [1:0]                      safe;
    logic [1:0]                      rd_en;
    logic [NUM_BANKS*BANK_LANES-1:0] plane_data;
    logic                            plane_valid;

    always_ff @(posedge clk)
    begin
        x_q      <= x_data_i;
        // ceil(dimension / BANK_LANES)
        chunks_q <= chunk_idx_t'(dimension_i >> TREE_DEPTH)
                  + chunk_idx_t'(|dimension_i[TREE_DEPTH-1:0]);
    end

    plane_buffer #(
        .NUM_BANKS       (NUM_BANKS),
        .BANK_LANES      (BANK_LANES),
        .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
    ) u_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .a_data_i      (a_data_i),
        .a_valid_i     (a_valid_i),
        .bits_i        (bits_i),
        .rd_en_i       (rd_en),
        .a_ready_o     (a_ready_o),
        .safe_o        (safe),
        .plane_data_o  (plane_data),
        .plane_valid_o (plane_valid)
    );

    plane_sequencer #(
        .NUM_BANKS   (NUM_BANKS),
        .X_ADDR_BITS (X_ADDR_BITS)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .x_ready_i (x_ready_i),
        .bits_i    (bits_i),
        .chunks_i  (chunks_q),
        .samples_i (samples_i),
        .epochs_i  (epochs_i),
        .safe_i    (safe),
        .rd_en_o   (rd_en),
        .x_addr_o  (x_addr_o),
        .done_o    (done_o)
    );

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        bank_dot_unit #(
            .BANK_LANES (BANK_LANES),
            .TREE_DEPTH (TREE_DEPTH)
        ) u_bank (
            .clk           (clk),
            .rst_n         (rst_n),
            .a_bits_i      (plane_data[b*BANK_LANES +: BANK_LANES]),  // this bank's lanes
            .x_i           (x_q),
            .plane_valid_i (plane_valid),
            .bits_i        (bits_i),
            .chunks_i      (chunks_q),
            .dot_o         (dot_o[b]),
            .dot_valid_o   (dot_valid_o[b])
        );
    end

endmodule

// ==== rtl/bank_dot_unit.sv ====
// one bank: mask x by plane bits, tree sum, scale by plane weight, accumulate
`timescale 1ns/1ps

module bank_dot_unit
    import sgd_data_pkg::*;
    import sgd_ctrl_pkg::*;
#(
    parameter int BANK_LANES = 8,
    parameter int TREE_DEPTH = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [BANK_LANES-1:0]     a_bits_i,
    input  x_elem_t [BANK_LANES-1:0]  x_i,
    input  logic                      plane_valid_i,
    input  plane_idx_t                bits_i,
    input  chunk_idx_t                chunks_i,
    output x_elem_t                   dot_o,
    output logic                      dot_valid_o
);
    psum_t [BANK_LANES-1:0] masked_q;
    logic                   masked_vld_q;
    psum_t                  tree_sum;
    logic                   tree_vld;
    acc_t                   tree_ext;       // sum with fraction bits appended
    plane_idx_t             plane_q;        // plane of the current tree output
    chunk_idx_t             chunk_q;
    acc_t                   shift_q;
    logic                   shift_vld_q;
    logic                   first_q;        // loads the accumulator
    logic                   last_q;         // closes the sample
    acc_t                   acc_q;
    logic                   acc_done_q;
    x_elem_t                res_q;
    logic                   res_vld_q;

    assign tree_ext = {tree_sum, {FRAC_BITS{1'b0}}};

    adder_tree #(
        .TREE_DEPTH (TREE_DEPTH)
    ) u_tree (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_i        (masked_q),
        .in_valid_i  (masked_vld_q),
        .sum_o       (tree_sum),
        .sum_valid_o (tree_vld)
    );

    always_ff @(posedge clk)
    begin
        for (int j = 0; j < BANK_LANES; j++)
            masked_q[j] <= a_bits_i[j] ? x_i[j] : '0;
        shift_q <= tree_ext >>> (6'(plane_q) + 6'd1);   // plane 0 weighs 1/2
        first_q <= (plane_q == '0) && (chunk_q == '0);
        last_q  <= (plane_q == bits_i - 5'd1) && (chunk_q == chunks_i - 12'd1);
        if (shift_vld_q)
            acc_q <= first_q ? shift_q : acc_q + shift_q;
        if (acc_done_q)
            res_q <= acc_q[FRAC_BITS+31:FRAC_BITS];   // drop fraction
        if (res_vld_q)
            dot_o <= res_q;     // held until next sample
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            masked_vld_q <= 1'b0;
            shift_vld_q  <= 1'b0;
            acc_done_q   <= 1'b0;
            res_vld_q    <= 1'b0;
            dot_valid_o  <= 1'b0;
            plane_q      <= '0;
            chunk_q      <= '0;
        end
        else
        begin
            masked_vld_q <= plane_valid_i;
            shift_vld_q  <= tree_vld;
            acc_done_q   <= shift_vld_q & last_q;
            res_vld_q    <= acc_done_q;
            dot_valid_o  <= res_vld_q;
            if (tree_vld)
            begin
                plane_q <= plane_q + 5'd1;
                if (plane_q == bits_i - 5'd1)
                begin
                    plane_q <= '0;
                    chunk_q <= (chunk_q == chunks_i - 12'd1) ? '0 : chunk_q + 12'd1;
                end
            end
        end
    end

endmodule

// ==== rtl/adder_tree.sv ====
// pipelined pairwise adder tree, one level per cycle, valid travels with data
`timescale 1ns/1ps

module adder_tree
    import sgd_data_pkg::*;
#(
    parameter int TREE_DEPTH = 3
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  psum_t [(1 << TREE_DEPTH)-1:0]    in_i,
    input  logic                             in_valid_i,
    output psum_t                            sum_o,
    output logic                             sum_valid_o
);
    localparam int LEAVES = 1 << TREE_DEPTH;

    for (genvar l = 0; l < TREE_DEPTH; l++)
    begin : g_lvl
        localparam int N = LEAVES >> (l + 1);   // sums out of this level

        psum_t [2*N-1:0] src;
        logic            src_vld;
        psum_t [N-1:0]   sum_q;
        logic            vld_q;

        if (l == 0)
        begin : g_first
            assign src     = in_i;
            assign src_vld = in_valid_i;
        end
        else
        begin : g_next
            assign src     = g_lvl[l-1].sum_q;
            assign src_vld = g_lvl[l-1].vld_q;
        end

        always_ff @(posedge clk)
        begin
            for (int k = 0; k < N; k++)
                sum_q[k] <= src[2*k] + src[2*k+1];     // wraps in 32 bits
        end

        always_ff @(posedge clk)
        begin
            if (!rst_n)
                vld_q <= 1'b0;
            else
                vld_q <= src_vld;
        end
    end

    assign sum_o       = g_lvl[TREE_DEPTH-1].sum_q[0];
    assign sum_valid_o = g_lvl[TREE_DEPTH-1].vld_q;

endmodule

// ==== rtl/plane_sequencer.sv ====
// control fsm: epochs, sample groups, chunks and planes; fifo reads and x addressing
`timescale 1ns/1ps

module plane_sequencer
    import sgd_ctrl_pkg::*;
#(
    parameter int NUM_BANKS   = 4,
    parameter int X_ADDR_BITS = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  logic                   x_ready_i,
    input  plane_idx_t             bits_i,
    input  chunk_idx_t             chunks_i,
    input  sample_cnt_t            samples_i,
    input  epoch_cnt_t             epochs_i,
    input  logic [1:0]             safe_i,
    output logic [1:0]             rd_en_o,
    output logic [X_ADDR_BITS-1:0] x_addr_o,
    output logic                   done_o
);
    seq_state_t  state;
    epoch_cnt_t  epoch_idx;     // 1-based once an epoch is running
    sample_cnt_t sample_idx;
    chunk_idx_t  chunk_idx;
    plane_idx_t  plane_idx;
    logic        rd_sel;        // fifo of the next chunk, kept across samples
    logic        cur;           // fifo read in the current compute state
    logic        last_plane;
    logic        last_chunk;

    assign cur        = (state == SEQ_COMP1);
    assign last_plane = (plane_idx == bits_i - 5'd1);
    assign last_chunk = (chunk_idx == chunks_i - 12'd1);
    assign done_o     = (state == SEQ_END);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= SEQ_IDLE;
            epoch_idx  <= '0;
            sample_idx <= '0;
            chunk_idx  <= '0;
            plane_idx  <= '0;
            rd_sel     <= 1'b0;
            rd_en_o    <= 2'b00;
            x_addr_o   <= '0;
        end
        else
        begin
            rd_en_o <= 2'b00;   // strobes last one cycle
            case (state)
                SEQ_IDLE:
                begin
                    if (start_i)
                        state <= SEQ_START;
                end
                SEQ_START:
                begin
                    epoch_idx <= '0;
                    state     <= SEQ_EPOCH;
                end
                SEQ_EPOCH:
                begin
                    sample_idx <= '0;
                    epoch_idx  <= epoch_idx + 10'd1;
                    if (epoch_idx == epochs_i)
                        state <= SEQ_END;
                    else
                        state <= SEQ_EPOCH_WAIT;
                end
                SEQ_EPOCH_WAIT:
                begin
                    // first epoch runs on the initial x
                    if (epoch_idx == 10'd1 || x_ready_i)
                        state <= SEQ_SAMPLE;
                end
                SEQ_SAMPLE:
                begin
                    plane_idx <= '0;
                    chunk_idx <= '0;
                    if (sample_idx >= samples_i)
                        state <= SEQ_EPOCH;
                    else
                    begin
                        sample_idx <= sample_idx + sample_cnt_t'(NUM_BANKS);  // one per bank
                        state      <= rd_sel ? SEQ_COMP1 : SEQ_COMP0;
                    end
                end
                SEQ_COMP0, SEQ_COMP1:
                begin
                    if (safe_i[cur])    // otherwise stall in place
                    begin
                        rd_en_o[cur] <= 1'b1;
                        if (plane_idx == '0)
                            x_addr_o <= chunk_idx[X_ADDR_BITS-1:0];  // new chunk of x
                        plane_idx <= plane_idx + 5'd1;
                        if (last_plane)
                        begin
                            plane_idx <= '0;
                            chunk_idx <= chunk_idx + 12'd1;
                            rd_sel    <= ~cur;
                            if (last_chunk)
                                state <= SEQ_SAMPLE;
                            else
                                state <= cur ? SEQ_COMP0 : SEQ_COMP1;
                        end
                    end
                end
                SEQ_END:
                begin
                    if (start_i)
                        state <= SEQ_START;     // new run without reset
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/plane_buffer.sv ====
// ping-pong plane buffer: input register, chunk steering, two fifos, merged read port
`timescale 1ns/1ps

module plane_buffer
    import sgd_ctrl_pkg::*;
#(
    parameter int NUM_BANKS       = 4,
    parameter int BANK_LANES      = 8,
    parameter int FIFO_DEPTH_BITS = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [NUM_BANKS*BANK_LANES-1:0] a_data_i,
    input  logic                            a_valid_i,
    input  plane_idx_t                      bits_i,
    input  logic [1:0]                      rd_en_i,
    output logic                            a_ready_o,
    output logic [1:0]                      safe_o,
    output logic [NUM_BANKS*BANK_LANES-1:0] plane_data_o,
    output logic                            plane_valid_o
);
    localparam int W = NUM_BANKS * BANK_LANES;

    logic [W-1:0]                   in_data_q;
    logic                           in_vld_q;
    logic [W-1:0]                   wr_data_q;
    logic [1:0]                     wr_en_q;
    logic                           wr_sel;     // fifo taking the current chunk
    plane_idx_t                     wr_cnt;     // words of the chunk so far
    logic [1:0]                     af;
    logic [1:0]                     empty;
    logic [1:0]                     rd_vld;
    logic [1:0][W-1:0]              rd_data;
    logic [1:0][FIFO_DEPTH_BITS:0]  cnt;

    assign a_ready_o = ~(af[0] | af[1]);

    always_ff @(posedge clk)
    begin
        in_data_q    <= a_data_i;
        wr_data_q    <= in_data_q;
        plane_data_o <= rd_vld[0] ? rd_data[0] : rd_data[1];   // at most one valid
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            in_vld_q      <= 1'b0;
            wr_en_q       <= 2'b00;
            wr_sel        <= 1'b0;
            wr_cnt        <= '0;
            plane_valid_o <= 1'b0;
        end
        else
        begin
            in_vld_q      <= a_valid_i & a_ready_o;
            wr_en_q       <= in_vld_q ? (wr_sel ? 2'b10 : 2'b01) : 2'b00;
            plane_valid_o <= |rd_vld;
            if (in_vld_q)
            begin
                wr_cnt <= wr_cnt + 5'd1;
                if (wr_cnt == bits_i - 5'd1)
                begin
                    wr_cnt <= '0;
                    wr_sel <= ~wr_sel;      // chunk done, switch fifo
                end
            end
        end
    end

    for (genvar f = 0; f < 2; f++)
    begin : g_fifo
        plane_fifo #(
            .WIDTH      (W),
            .DEPTH_BITS (FIFO_DEPTH_BITS)
        ) u_fifo (
            .clk           (clk),
            .rst_n         (rst_n),
            .we_i          (wr_en_q[f]),
            .din_i         (wr_data_q),
            .re_i          (rd_en_i[f]),
            .dout_o        (rd_data[f]),
            .valid_o       (rd_vld[f]),
            .empty_o       (empty[f]),
            .almost_full_o (af[f]),
            .count_o       (cnt[f])
        );

        // last word already leaving this cycle counts as empty
        assign safe_o[f] = ~(empty[f] | ((cnt[f] == 1) & rd_en_i[f]));
    end

endmodule

// ==== rtl/plane_fifo.sv ====
// circular buffer fifo in distributed ram with occupancy count and read valid
`timescale 1ns/1ps

module plane_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_BITS = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we_i,
    input  logic [WIDTH-1:0]    din_i,
    input  logic                re_i,
    output logic [WIDTH-1:0]    dout_o,
    output logic                valid_o,
    output logic                empty_o,
    output logic                almost_full_o,
    output logic [DEPTH_BITS:0] count_o
);
    localparam int DEPTH = 1 << DEPTH_BITS;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_BITS-1:0] wr_ptr;
    logic [DEPTH_BITS-1:0] rd_ptr;
    logic                  do_wr;
    logic                  do_rd;

    assign empty_o       = (count_o == '0);
    assign almost_full_o = (count_o >= (DEPTH_BITS+1)'(DEPTH - 4));  // 4 slots of slack
    assign do_wr         = we_i & (count_o != (DEPTH_BITS+1)'(DEPTH));  // drop on full
    assign do_rd         = re_i & ~empty_o;

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= din_i;
        if (do_rd)
            dout_o <= mem[rd_ptr];      // data one cycle after re
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
            valid_o <= 1'b0;
        end
        else
        begin
            valid_o <= do_rd;
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;    // both or neither
            endcase
        end
    end

endmodule

// ==== rtl/sgd_ctrl_pkg.sv ====
// sequencer state encoding and loop counter types
package sgd_ctrl_pkg;

    typedef enum logic [3:0] {
        SEQ_IDLE,           // waiting for start pulse
        SEQ_START,          // clear epoch count
        SEQ_EPOCH,          // epoch boundary, check for end
        SEQ_EPOCH_WAIT,     // hold until host says x is updated
        SEQ_SAMPLE,         // next group of NUM_BANKS samples
        SEQ_COMP0,          // planes from fifo 0
        SEQ_COMP1,          // planes from fifo 1
        SEQ_END
    } seq_state_t;

    typedef logic [4:0]  plane_idx_t;      // bit plane, 0 is msb
    typedef logic [11:0] chunk_idx_t;      // BANK_LANES features per chunk
    typedef logic [9:0]  epoch_cnt_t;
    typedef logic [31:0] sample_cnt_t;

endpackage

// ==== rtl/sgd_data_pkg.sv ====
// datapath types: model element, adder tree sum, fixed point accumulator
package sgd_data_pkg;

    // fraction bits kept below the binary point in the accumulator
    localparam int FRAC_BITS = 4;

    typedef logic signed [31:0] x_elem_t;               // one model element
    typedef logic signed [31:0] psum_t;                 // tree sum, wraps on overflow
    typedef logic signed [31+FRAC_BITS:0] acc_t;        // 32.4 running dot product

endpackage
